/* bubble_defines.svh */
`ifndef BUBBLE_DEFINES_SVH
`define BUBBLE_DEFINES_SVH

// Page store geometry
`define BUBBLE_PAGES      16
`define BUBBLE_PAGE_WORDS 4

// Page forced by the replicator while bootloop is on
`define BUBBLE_BOOT_PAGE  0

// Word width, split evenly over the two data lines
`define BUBBLE_WORD_BITS  16

`endif

/* bubble_geom_pkg.sv */
`include "bubble_defines.svh"

package bubble_geom_pkg;

    typedef logic [$clog2(`BUBBLE_PAGES)-1:0]          page_idx_t;
    typedef logic [$clog2(`BUBBLE_PAGE_WORDS)-1:0]     word_idx_t;
    typedef logic [$clog2(`BUBBLE_WORD_BITS / 2)-1:0]  bit_idx_t; // Shift step within a word

    typedef struct packed {
        logic [`BUBBLE_WORD_BITS/2-1:0] hi; // Line 1
        logic [`BUBBLE_WORD_BITS/2-1:0] lo; // Line 0
    } page_bytes_t;

    // Loader writes bytes, shifter reads lanes[line][step]
    typedef union packed {
        page_bytes_t                         bytes;
        logic [1:0][`BUBBLE_WORD_BITS/2-1:0] lanes;
    } page_word_u;

endpackage

/* bubble_ctrl_pkg.sv */
package bubble_ctrl_pkg;

    // Access sequencing
    typedef enum logic [1:0] {
        IDLE     = 2'd0, // No page selected
        FETCH    = 2'd1, // First word on its way from the store
        SHIFTING = 2'd2  // Accepting shift strobes
    } access_state_e;

    // Replicator request as seen by the FSM
    typedef struct packed {
        bubble_geom_pkg::page_idx_t page;
        logic                       bootloop; // Overrides page
    } access_cmd_t;

endpackage

/* bubble_access_if.sv */
interface bubble_access_if;

    logic                       fetch;
    bubble_geom_pkg::page_idx_t fetch_page;
    bubble_geom_pkg::word_idx_t word_idx;
    logic                       word_ready;
    logic                       shift_en;
    logic                       advance_word;
    logic                       page_end;
    logic                       clear;

    modport fsm (
        output fetch, fetch_page, shift_en, clear,
        input  word_ready, advance_word, page_end
    );

    modport counter (
        input  shift_en, clear,
        output word_idx, advance_word, page_end
    );

    modport store (
        input  fetch, fetch_page, word_idx,
        output word_ready
    );

    modport shifter (
        input  word_ready, shift_en, clear
    );

endinterface

/* bubble_access_fsm.sv */
`include "bubble_defines.svh"

module bubble_access_fsm (
    input  logic                        temperature_low,
    input  logic                        rst,
    input  logic                        rep_strobe,
    input  bubble_ctrl_pkg::access_cmd_t cmd,
    input  logic                        shift_strobe,
    output logic                        page_active,
    bubble_access_if.fsm                acc
);

    bubble_ctrl_pkg::access_state_e state_q;
    bubble_ctrl_pkg::access_state_e state_d;
    bubble_geom_pkg::page_idx_t     page_q;
    logic                           rep_accept;
    logic                           prefetch_q; // Next word requested by the counter
    logic                           end_q;      // Last bit went out last cycle

    assign rep_accept  = rep_strobe && (state_q == bubble_ctrl_pkg::IDLE);
    assign page_active = (state_q != bubble_ctrl_pkg::IDLE);

    assign acc.clear      = rep_accept;
    assign acc.fetch_page = page_q;

    // First word is requested once, later words by prefetch
    assign acc.fetch = ((state_q == bubble_ctrl_pkg::FETCH) && !acc.word_ready) || prefetch_q;

    // Hold off shifts while the page is closing
    assign acc.shift_en = shift_strobe && (state_q == bubble_ctrl_pkg::SHIFTING) && !end_q;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            bubble_ctrl_pkg::IDLE:
            begin
                if (rep_accept)
                begin
                    state_d = bubble_ctrl_pkg::FETCH;
                end
            end
            bubble_ctrl_pkg::FETCH:
            begin
                if (acc.word_ready)
                begin
                    state_d = bubble_ctrl_pkg::SHIFTING;
                end
            end
            bubble_ctrl_pkg::SHIFTING:
            begin
                if (end_q)
                begin
                    state_d = bubble_ctrl_pkg::IDLE; // page_active drops one cycle after last bit
                end
            end
            default:
            begin
                state_d = bubble_ctrl_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge temperature_low)
    begin
        if (rst)
        begin
            state_q    <= bubble_ctrl_pkg::IDLE;
            page_q     <= '0;
            prefetch_q <= 1'b0;
            end_q      <= 1'b0;
        end
        else
        begin
            state_q    <= state_d;
            prefetch_q <= acc.advance_word && !acc.page_end;
            end_q      <= acc.page_end;
            if (rep_accept)
            begin
                // Bootloop pins the replicator to one page
                page_q <= cmd.bootloop ? bubble_geom_pkg::page_idx_t'(`BUBBLE_BOOT_PAGE)
                                       : cmd.page;
            end
        end
    end

endmodule

/* bubble_rotation_counter.sv */
`include "bubble_defines.svh"

module bubble_rotation_counter (
    input  logic            temperature_low,
    input  logic            rst,
    bubble_access_if.counter acc
);

    localparam bubble_geom_pkg::word_idx_t LAST_WORD =
        bubble_geom_pkg::word_idx_t'(`BUBBLE_PAGE_WORDS - 1);

    bubble_geom_pkg::bit_idx_t  bit_q;
    bubble_geom_pkg::word_idx_t word_q;
    logic                       last_bit;
    logic                       last_word;

    assign last_bit  = (bit_q == '1);
    assign last_word = (word_q == LAST_WORD);

    assign acc.word_idx     = word_q;
    assign acc.advance_word = acc.shift_en && last_bit;
    assign acc.page_end     = acc.advance_word && last_word; // Final bit pair of the page

    always_ff @(posedge temperature_low)
    begin
        if (rst || acc.clear)
        begin
            bit_q  <= '0;
            word_q <= '0;
        end
        else if (acc.shift_en)
        begin
            bit_q <= bit_q + 1'b1; // Wraps after the eighth step
            if (last_bit)
            begin
                word_q <= word_q + 1'b1;
            end
        end
    end

endmodule

/* bubble_page_store.sv */
`include "bubble_defines.svh"

module bubble_page_store (
    input  logic                        temperature_low,
    input  logic                        load_strobe,
    input  bubble_geom_pkg::page_idx_t  load_page,
    input  bubble_geom_pkg::word_idx_t  load_word,
    input  logic [`BUBBLE_WORD_BITS-1:0] load_data,
    bubble_access_if.store              acc,
    output bubble_geom_pkg::page_word_u rd_word
);

    localparam int DEPTH = `BUBBLE_PAGES * `BUBBLE_PAGE_WORDS;

    bubble_geom_pkg::page_word_u mem [DEPTH];
    bubble_geom_pkg::page_word_u wr_word;

    // Low byte feeds line 0, high byte line 1
    always_comb
    begin
        wr_word.bytes.hi = load_data[`BUBBLE_WORD_BITS-1:`BUBBLE_WORD_BITS/2];
        wr_word.bytes.lo = load_data[`BUBBLE_WORD_BITS/2-1:0];
    end

    always_ff @(posedge temperature_low)
    begin
        if (load_strobe)
        begin
            mem[{load_page, load_word}] <= wr_word;
        end
    end

    // One cycle read latency
    always_ff @(posedge temperature_low)
    begin
        if (acc.fetch)
        begin
            rd_word <= mem[{acc.fetch_page, acc.word_idx}];
        end
    end

    always_ff @(posedge temperature_low)
    begin
        acc.word_ready <= acc.fetch; // Single cycle pulse per fetch
    end

endmodule

/* bubble_shifter.sv */
module bubble_shifter (
    input  logic                        temperature_low,
    input  logic                        rst,
    input  bubble_geom_pkg::page_word_u rd_word,
    bubble_access_if.shifter            acc,
    output logic                        dout0,
    output logic                        dout1,
    output logic                        dout_valid
);

    bubble_geom_pkg::page_word_u word_q;
    bubble_geom_pkg::page_word_u cur_word;
    bubble_geom_pkg::bit_idx_t   bit_q; // Mirrors the counter's bit position

    // A shift can land on the same edge as the prefetched word
    always_comb
    begin
        cur_word = acc.word_ready ? rd_word : word_q;
    end

    always_ff @(posedge temperature_low)
    begin
        if (acc.word_ready)
        begin
            word_q <= rd_word;
        end
    end

    always_ff @(posedge temperature_low)
    begin
        if (rst)
        begin
            bit_q      <= '0;
            dout0      <= 1'b0;
            dout1      <= 1'b0;
            dout_valid <= 1'b0;
        end
        else
        begin
            dout_valid <= acc.shift_en;
            if (acc.clear)
            begin
                bit_q <= '0;
            end
            else if (acc.shift_en)
            begin
                // LSB first on both lines
                dout0 <= cur_word.lanes[0][bit_q];
                dout1 <= cur_word.lanes[1][bit_q];
                bit_q <= bit_q + 1'b1;
            end
        end
    end

endmodule

/* bubble_emulator_top.sv */
`include "bubble_defines.svh"

module bubble_emulator_top (
    input  logic                                    temperature_low,
    input  logic                                    rst,

    input  logic                                    load_strobe,
    input  logic [$clog2(`BUBBLE_PAGES)-1:0]        load_page,
    input  logic [$clog2(`BUBBLE_PAGE_WORDS)-1:0]   load_word,
    input  logic [`BUBBLE_WORD_BITS-1:0]            load_data,

    input  logic                                    rep_strobe,
    input  logic [$clog2(`BUBBLE_PAGES)-1:0]        rep_page,
    input  logic                                    bootloop,

    input  logic                                    shift_strobe,

    output logic                                    dout0,
    output logic                                    dout1,
    output logic                                    dout_valid,
    output logic                                    page_active
);

    bubble_access_if              acc ();
    bubble_ctrl_pkg::access_cmd_t cmd;
    bubble_geom_pkg::page_word_u  rd_word;
    logic                         load_en;

    assign cmd.page     = rep_page;
    assign cmd.bootloop = bootloop;
    assign load_en      = load_strobe && !page_active; // No loads during a page read

    bubble_access_fsm i_fsm (
        .temperature_low (temperature_low),
        .rst             (rst),
        .rep_strobe      (rep_strobe),
        .cmd             (cmd),
        .shift_strobe    (shift_strobe),
        .page_active     (page_active),
        .acc             (acc.fsm)
    );

    bubble_rotation_counter i_counter (
        .temperature_low (temperature_low),
        .rst             (rst),
        .acc             (acc.counter)
    );

    bubble_page_store i_store (
        .temperature_low (temperature_low),
        .load_strobe     (load_en),
        .load_page       (load_page),
        .load_word       (load_word),
        .load_data       (load_data),
        .acc             (acc.store),
        .rd_word         (rd_word)
    );

    bubble_shifter i_shifter (
        .temperature_low (temperature_low),
        .rst             (rst),
        .rd_word         (rd_word),
        .acc             (acc.shifter),
        .dout0           (dout0),
        .dout1           (dout1),
        .dout_valid      (dout_valid)
    );

endmodule

/* bubble_checker.sv */
module bubble_checker (
    input logic temperature_low,
    input logic rst,
    input logic shift_strobe,
    input logic dout_valid,
    input logic page_active
);
    timeunit 1ns;
    timeprecision 100ps;

    // Output pulses only inside a page read
    valid_inside_page: assert property (
        @(posedge temperature_low) disable iff (rst)
        dout_valid |-> page_active
    )
        else $error("dout_valid high while page_active is low");

    single_cycle_valid: assert property (
        @(posedge temperature_low) disable iff (rst)
        dout_valid |=> !dout_valid
    )
        else $error("dout_valid high for two cycles in a row");

    // Shifts are taken once the first word has settled, two cycles into the page
    valid_after_shift: assert property (
        @(posedge temperature_low) disable iff (rst)
        shift_strobe && page_active && $past(page_active) && $past(page_active, 2)
            |=> dout_valid
    )
        else $error("accepted shift gave no dout_valid one cycle later");

    // No pulse without a shift behind it
    valid_has_shift: assert property (
        @(posedge temperature_low) disable iff (rst)
        dout_valid |-> $past(shift_strobe && page_active)
    )
        else $error("dout_valid without a shift strobe inside a page one cycle earlier");

    reset_clears_active: assert property (
        @(posedge temperature_low)
        rst |=> !page_active
    )
        else $error("page_active high in the cycle after reset");

endmodule

/* bubble_emulator_tb.sv */
`include "bubble_defines.svh"

module bubble_emulator_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PAGE_SHIFTS    = `BUBBLE_PAGE_WORDS * 8;
    localparam int BOOT_READS     = 3;
    localparam int PAGES_TESTED   = `BUBBLE_PAGES + BOOT_READS;
    localparam int TIMEOUT_CYCLES = PAGES_TESTED * PAGE_SHIFTS * 4 + 500;

    logic                         temperature_low;
    logic                         rst;
    logic                         load_strobe;
    bubble_geom_pkg::page_idx_t   load_page;
    bubble_geom_pkg::word_idx_t   load_word;
    logic [`BUBBLE_WORD_BITS-1:0] load_data;
    logic                         rep_strobe;
    bubble_geom_pkg::page_idx_t   rep_page;
    logic                         bootloop;
    logic                         shift_strobe;
    logic                         dout0;
    logic                         dout1;
    logic                         dout_valid;
    logic                         page_active;

    logic [`BUBBLE_WORD_BITS-1:0] model [`BUBBLE_PAGES][`BUBBLE_PAGE_WORDS]; // Loaded page images
    int                           cycles;
    int                           shift_num; // Pulses seen in the current page read
    int                           cur_page;
    bit                           cur_boot;
    bit                           reading;

    bubble_emulator_top i_dut (
        .temperature_low (temperature_low),
        .rst             (rst),
        .load_strobe     (load_strobe),
        .load_page       (load_page),
        .load_word       (load_word),
        .load_data       (load_data),
        .rep_strobe      (rep_strobe),
        .rep_page        (rep_page),
        .bootloop        (bootloop),
        .shift_strobe    (shift_strobe),
        .dout0           (dout0),
        .dout1           (dout1),
        .dout_valid      (dout_valid),
        .page_active     (page_active)
    );

    bind bubble_emulator_top bubble_checker i_checker (
        .temperature_low (temperature_low),
        .rst             (rst),
        .shift_strobe    (shift_strobe),
        .dout_valid      (dout_valid),
        .page_active     (page_active)
    );

    initial
    begin
        temperature_low = 1'b0;
        forever #4 temperature_low = ~temperature_low;
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected)
        begin
            $display("mismatch at %0d ns: %s (got %0d, expected %0d)",
                     $time, what, actual, expected);
            stop_run();
        end
    endtask

    // Line 0 takes the low byte, line 1 the high byte, LSB first
    function automatic logic [1:0] expected_pair(input int page, input int shift_no,
                                                 input bit boot);
        int                           p;
        int                           b;
        logic [`BUBBLE_WORD_BITS-1:0] w;
        p = boot ? `BUBBLE_BOOT_PAGE : page;
        w = model[p][shift_no / 8];
        b = shift_no % 8;
        return {w[b + `BUBBLE_WORD_BITS / 2], w[b]};
    endfunction

    always @(negedge temperature_low)
    begin
        if (dout_valid)
        begin
            if (!reading)
            begin
                $display("dout_valid pulsed while no page read was in progress");
                stop_run();
            end
            else if (shift_num >= PAGE_SHIFTS)
            begin
                $display("more dout_valid pulses than bit pairs in one page");
                stop_run();
            end
            else
            begin
                check({dout1, dout0}, expected_pair(cur_page, shift_num, cur_boot),
                      $sformatf("bit pair %0d of page %0d", shift_num, cur_page));
                shift_num++;
            end
        end
    end

    always @(posedge temperature_low)
    begin
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
        else
        begin
            cycles++;
        end
    end

    task automatic load_pages();
        logic [31:0] rnd;
        for (int p = 0; p < `BUBBLE_PAGES; p++)
        begin
            for (int w = 0; w < `BUBBLE_PAGE_WORDS; w++)
            begin
                rnd         = $urandom();
                load_strobe = 1'b1;
                load_page   = bubble_geom_pkg::page_idx_t'(p);
                load_word   = bubble_geom_pkg::word_idx_t'(w);
                load_data   = rnd[`BUBBLE_WORD_BITS-1:0];
                model[p][w] = rnd[`BUBBLE_WORD_BITS-1:0];
                @(posedge temperature_low);
                #1;
            end
        end
        load_strobe = 1'b0;
    endtask

    // Strobes with no page selected
    task automatic idle_shifts();
        for (int i = 0; i < 3; i++)
        begin
            shift_strobe = 1'b1;
            @(posedge temperature_low);
            #1;
            shift_strobe = 1'b0;
            repeat (2) @(posedge temperature_low);
            #1;
        end
    endtask

    task automatic start_page(input int page, input bit boot);
        cur_page   = page;
        cur_boot   = boot;
        shift_num  = 0;
        reading    = 1'b1;
        rep_strobe = 1'b1;
        rep_page   = bubble_geom_pkg::page_idx_t'(page);
        bootloop   = boot;
        @(negedge temperature_low);
        check(page_active, 0, "page_active before rep_strobe is taken");
        @(posedge temperature_low);
        #1;
        rep_strobe = 1'b0;
        check(page_active, 1, "page_active one cycle after rep_strobe");
        repeat (2) @(posedge temperature_low); // First word reaches the shifter
        #1;
    endtask

    task automatic shift_once(input bit last, input bit inject);
        int gap;
        gap          = $urandom_range(3, 1);
        shift_strobe = 1'b1;
        @(negedge temperature_low);
        check(dout_valid, 0, "dout_valid before the shift is taken");
        @(posedge temperature_low);
        #1;
        shift_strobe = 1'b0;
        if (inject)
        begin
            // Both must be dropped mid page
            rep_strobe  = 1'b1;
            rep_page    = bubble_geom_pkg::page_idx_t'(`BUBBLE_PAGES - 1);
            load_strobe = 1'b1;
            load_page   = bubble_geom_pkg::page_idx_t'(`BUBBLE_PAGES - 1);
            load_word   = bubble_geom_pkg::word_idx_t'(`BUBBLE_PAGE_WORDS - 1);
            load_data   = ~model[`BUBBLE_PAGES - 1][`BUBBLE_PAGE_WORDS - 1];
        end
        @(negedge temperature_low);
        check(dout_valid, 1, "dout_valid one cycle after shift_strobe");
        if (last)
        begin
            check(page_active, 1, "page_active during the final dout_valid");
        end
        @(posedge temperature_low);
        #1;
        rep_strobe  = 1'b0;
        load_strobe = 1'b0;
        if (last)
        begin
            check(page_active, 0, "page_active one cycle after the final dout_valid");
        end
        repeat (gap - 1)
        begin
            @(posedge temperature_low);
            #1;
        end
    endtask

    task automatic read_page(input int page, input bit boot, input bit inject);
        start_page(page, boot);
        for (int i = 0; i < PAGE_SHIFTS; i++)
        begin
            shift_once(i == PAGE_SHIFTS - 1, inject && (i == 10));
        end
        check(shift_num, PAGE_SHIFTS, "dout_valid pulses in one page read");
        reading = 1'b0;
    endtask

    initial
    begin
        int pg;
        void'($urandom(86964));
        cycles       = 0;
        shift_num    = 0;
        cur_page     = 0;
        cur_boot     = 1'b0;
        reading      = 1'b0;
        rst          = 1'b1;
        load_strobe  = 1'b0;
        load_page    = '0;
        load_word    = '0;
        load_data    = '0;
        rep_strobe   = 1'b0;
        rep_page     = '0;
        bootloop     = 1'b0;
        shift_strobe = 1'b0;
        repeat (2) @(posedge temperature_low);
        #1;
        rst = 1'b0;
        @(negedge temperature_low);
        check(dout_valid, 0, "dout_valid after reset");
        check(page_active, 0, "page_active after reset");
        @(posedge temperature_low);
        #1;

        load_pages();
        idle_shifts();
        for (int p = 0; p < `BUBBLE_PAGES; p++)
        begin
            read_page(p, 1'b0, p == 0);
        end

        for (int k = 0; k < BOOT_READS; k++)
        begin
            pg = $urandom_range(`BUBBLE_PAGES - 1, 1); // Any page but the boot page
            read_page(pg, 1'b1, 1'b0);
        end
        bootloop = 1'b0;

        @(posedge temperature_low);
        #1;
        $display("Test passed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
bubble_geom_pkg.sv
bubble_ctrl_pkg.sv
bubble_access_if.sv
bubble_access_fsm.sv
bubble_rotation_counter.sv
bubble_page_store.sv
bubble_shifter.sv
bubble_emulator_top.sv
bubble_checker.sv
bubble_emulator_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
    --top-module bubble_emulator_tb -f flist.f -o sim_bubble

./obj_dir/sim_bubble
